/* verilog/dcache_macros.svh */
// Cache geometry for a 4-way, 2-set, 64-byte line data cache.
// The widths below must stay consistent with each other: the tag is
// the address width less the index and offset widths.
// Store size codes match the core's byte/half/word/double encoding.

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// --------------------
// Widths.
// --------------------
`define DC_ADDR_W   32
`define DC_DWORD_W  64
`define DC_LINE_W   512

// --------------------
// Geometry.
// --------------------
`define DC_WAYS     4
`define DC_SETS     2
`define DC_OFFSET_W 6
`define DC_INDEX_W  1
`define DC_TAG_W    25

// Store size codes.
`define DC_SZ_B     2'd0
`define DC_SZ_H     2'd1
`define DC_SZ_W     2'd2
`define DC_SZ_D     2'd3

`endif

/* verilog/dcache_pkg.sv */
// Shared types of the data cache.
// Widths come from the macros header, so it must be on the include path.

`include "dcache_macros.svh"

package dcache_pkg;

    // --------------------
    // Plain vectors.
    // --------------------
    typedef logic [ `DC_ADDR_W   - 1:0 ] addr_t;
    typedef logic [ `DC_TAG_W    - 1:0 ] tag_t;
    typedef logic [ `DC_INDEX_W  - 1:0 ] index_t;
    typedef logic [ `DC_OFFSET_W - 1:0 ] offset_t;
    typedef logic [ 1:0 ]                way_t;
    typedef logic [ `DC_DWORD_W  - 1:0 ] dword_t;
    typedef logic [ `DC_LINE_W   - 1:0 ] line_t;
    typedef logic [ 1:0 ]                size_t;

    // --------------------
    // Structs.
    // --------------------

    // Core request, held by the controller for the whole access.
    typedef struct packed {
        logic   write;
        size_t  size;
        addr_t  addr;
        dword_t wdata;
    } cache_req_t;

    // Tag array result for the addressed set.
    typedef struct packed {
        logic hit;
        way_t way;
        way_t victim_way;
        logic victim_dirty;
        tag_t victim_tag;
    } lookup_t;

    // Line-sized request toward the backing memory.
    typedef struct packed {
        logic  write;
        addr_t addr;
        line_t line;
    } mem_req_t;

    typedef enum logic [ 2:0 ] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT,
        RESPOND
    } ctrl_state_e;

endpackage

/* verilog/dcache_plru.sv */
// Tree pseudo-LRU for a 4-way cache, one 3-bit tree per set.
// Bit 0 is the root, bit 1 the left leaf, bit 2 the right leaf.
// A set bit points the victim search to the right.

`include "dcache_macros.svh"

module dcache_plru (
    input  logic               i_clk,
    input  logic               i_arst,
    input  dcache_pkg::index_t i_index,
    input  logic               i_touch,
    input  dcache_pkg::way_t   i_touch_way,
    output dcache_pkg::way_t   o_victim
);
    import dcache_pkg::*;

    logic [ 2:0 ] tree [ `DC_SETS ];
    logic [ 2:0 ] cur;

    assign cur = tree[ i_index ];

    // Root picks the half, then that half's leaf picks the way.
    assign o_victim = { cur[ 0 ], ( cur[ 0 ] ? cur[ 2 ] : cur[ 1 ] ) };

    // --------------------
    // Update on hit.
    // --------------------
    always_ff @( posedge i_clk, posedge i_arst ) begin
        if ( i_arst ) begin
            for ( int s = 0; s < `DC_SETS; s++ ) begin
                tree[ s ] <= '0;
            end
        end
        else if ( i_touch ) begin
            // Point away from the way just used.
            tree[ i_index ][ 0 ] <= ~i_touch_way[ 1 ];
            if ( i_touch_way[ 1 ] ) begin
                tree[ i_index ][ 2 ] <= ~i_touch_way[ 0 ];
            end
            else begin
                tree[ i_index ][ 1 ] <= ~i_touch_way[ 0 ];
            end
        end
    end

endmodule

/* verilog/dcache_tag_array.sv */
// Tag, valid and dirty bits for all ways and sets.
// Lookup is combinational on the index and tag inputs.
// A fill always lands in the victim way that the PLRU reports,
// so the PLRU must not move between the miss and the fill.

`include "dcache_macros.svh"

module dcache_tag_array (
    input  logic                i_clk,
    input  logic                i_arst,
    input  dcache_pkg::index_t  i_index,
    input  dcache_pkg::tag_t    i_tag,
    input  dcache_pkg::way_t    i_victim,
    input  logic                i_fill,
    input  dcache_pkg::way_t    i_store_way,
    input  logic                i_store,
    output dcache_pkg::lookup_t o_lookup
);
    import dcache_pkg::*;

    tag_t                  tags  [ `DC_SETS ][ `DC_WAYS ];
    logic [ `DC_WAYS-1:0 ] valid [ `DC_SETS ];
    logic [ `DC_WAYS-1:0 ] dirty [ `DC_SETS ];
    logic [ `DC_WAYS-1:0 ] match;

    // --------------------
    // Lookup.
    // --------------------
    always_comb begin
        for ( int w = 0; w < `DC_WAYS; w++ ) begin
            match[ w ] = valid[ i_index ][ w ] & ( tags[ i_index ][ w ] == i_tag );
        end

        o_lookup.hit = |match;
        o_lookup.way = '0;
        // Walk down so the lowest matching way wins.
        for ( int w = `DC_WAYS - 1; w >= 0; w-- ) begin
            if ( match[ w ] ) begin
                o_lookup.way = way_t'( w );
            end
        end

        o_lookup.victim_way   = i_victim;
        o_lookup.victim_dirty = valid[ i_index ][ i_victim ] & dirty[ i_index ][ i_victim ];
        o_lookup.victim_tag   = tags[ i_index ][ i_victim ];
    end

    // --------------------
    // State bits.
    // --------------------
    always_ff @( posedge i_clk, posedge i_arst ) begin
        if ( i_arst ) begin
            for ( int s = 0; s < `DC_SETS; s++ ) begin
                valid[ s ] <= '0;
                dirty[ s ] <= '0;
            end
        end
        else if ( i_fill ) begin
            // Fresh line from memory is clean.
            valid[ i_index ][ i_victim ] <= 1'b1;
            dirty[ i_index ][ i_victim ] <= 1'b0;
        end
        else if ( i_store ) begin
            dirty[ i_index ][ i_store_way ] <= 1'b1;
        end
    end

    // Tag storage.
    always_ff @( posedge i_clk ) begin
        if ( i_fill ) begin
            tags[ i_index ][ i_victim ] <= i_tag;
        end
    end

endmodule

/* verilog/dcache_data_array.sv */
// Line storage, one 512-bit line per way and set.
// Stores are assumed naturally aligned; offset bits below the
// access size are ignored. o_dword shows the merged data while
// i_store is high, so the store response needs no second read.

`include "dcache_macros.svh"

module dcache_data_array (
    input  logic                i_clk,
    input  dcache_pkg::index_t  i_index,
    input  dcache_pkg::way_t    i_way,
    input  dcache_pkg::offset_t i_offset,
    input  dcache_pkg::size_t   i_size,
    input  dcache_pkg::dword_t  i_wdata,
    input  logic                i_store,
    input  logic                i_fill,
    input  dcache_pkg::line_t   i_fill_line,
    output dcache_pkg::dword_t  o_dword,
    output dcache_pkg::line_t   o_line
);
    import dcache_pkg::*;

    line_t         mem [ `DC_SETS ][ `DC_WAYS ];
    line_t         cur_line;
    line_t         wr_line;
    line_t         rd_line;
    line_t         bit_mask;
    logic [ 7:0 ]  lanes;
    logic [ 2:0 ]  lane_off;
    logic [ 7:0 ]  dword_mask;
    logic [ 63:0 ] byte_mask;
    dword_t        wdata_sh;

    assign cur_line = mem[ i_index ][ i_way ];

    // --------------------
    // Store merge.
    // --------------------
    always_comb begin
        case ( i_size )
            `DC_SZ_B: lanes = 8'h01;
            `DC_SZ_H: lanes = 8'h03;
            `DC_SZ_W: lanes = 8'h0f;
            `DC_SZ_D: lanes = 8'hff;
        endcase
    end

    // Lanes 7, 3 and 1 together give the byte count minus one.
    assign lane_off   = i_offset[ 2:0 ] & ~{ lanes[ 7 ], lanes[ 3 ], lanes[ 1 ] };
    assign dword_mask = lanes << lane_off;
    assign byte_mask  = { 56'b0, dword_mask } << { i_offset[ 5:3 ], 3'b000 };
    assign wdata_sh   = i_wdata << { lane_off, 3'b000 };

    always_comb begin
        for ( int b = 0; b < `DC_LINE_W / 8; b++ ) begin
            bit_mask[ 8*b +: 8 ] = { 8{ byte_mask[ b ] } };
        end
    end

    // Data is copied to every doubleword and the mask picks the lanes.
    assign wr_line = ( cur_line & ~bit_mask ) | ( { 8{ wdata_sh } } & bit_mask );

    // --------------------
    // Read.
    // --------------------
    assign rd_line = i_store ? wr_line : cur_line;
    assign o_dword = rd_line[ i_offset[ 5:3 ] * `DC_DWORD_W +: `DC_DWORD_W ];
    assign o_line  = cur_line;

    // Fill takes priority. The controller never raises both.
    always_ff @( posedge i_clk ) begin
        if ( i_fill ) begin
            mem[ i_index ][ i_way ] <= i_fill_line;
        end
        else if ( i_store ) begin
            mem[ i_index ][ i_way ] <= wr_line;
        end
    end

endmodule

/* verilog/dcache_ctrl.sv */
// Miss sequencing and handshakes for the data cache.
// One access in flight: a request is taken only in IDLE.
// A miss writes back a dirty victim, refills, then repeats the lookup.
// Memory requests are held stable until i_mem_ready.

`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                   i_clk,
    input  logic                   i_arst,
    input  logic                   i_req_valid,
    input  dcache_pkg::cache_req_t i_req,
    input  logic                   i_rsp_ready,
    input  logic                   i_mem_ready,
    input  logic                   i_fill_valid,
    input  dcache_pkg::lookup_t    i_lookup,
    input  dcache_pkg::line_t      i_line,
    input  dcache_pkg::dword_t     i_dword,
    output logic                   o_req_ready,
    output logic                   o_rsp_valid,
    output logic                   o_rsp_hit,
    output dcache_pkg::dword_t     o_rsp_data,
    output logic                   o_mem_valid,
    output dcache_pkg::mem_req_t   o_mem_req,
    output dcache_pkg::index_t     o_index,
    output dcache_pkg::tag_t       o_tag,
    output dcache_pkg::offset_t    o_offset,
    output dcache_pkg::size_t      o_size,
    output dcache_pkg::dword_t     o_wdata,
    output dcache_pkg::way_t       o_way,
    output logic                   o_store,
    output logic                   o_fill,
    output logic                   o_touch
);
    import dcache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    cache_req_t  req_q;
    logic        miss_q;
    dword_t      rsp_data_q;
    logic        lookup_hit;

    // --------------------
    // Held request fields.
    // --------------------
    assign o_index  = req_q.addr[ `DC_OFFSET_W +: `DC_INDEX_W ];
    assign o_tag    = req_q.addr[ `DC_ADDR_W - 1 -: `DC_TAG_W ];
    assign o_offset = req_q.addr[ `DC_OFFSET_W - 1:0 ];
    assign o_size   = req_q.size;
    assign o_wdata  = req_q.wdata;

    assign lookup_hit = ( state == LOOKUP ) & i_lookup.hit;

    // Hit way for the lookup, victim way for write-back and refill.
    assign o_way   = ( state == LOOKUP ) ? i_lookup.way : i_lookup.victim_way;
    assign o_store = lookup_hit & req_q.write;
    assign o_touch = lookup_hit;
    assign o_fill  = ( state == REFILL_WAIT ) & i_fill_valid;

    // --------------------
    // Handshakes.
    // --------------------
    assign o_req_ready = ( state == IDLE );
    assign o_rsp_valid = ( state == RESPOND );
    assign o_rsp_hit   = ~miss_q;
    assign o_rsp_data  = rsp_data_q;

    assign o_mem_valid     = ( state == WRITEBACK ) | ( state == REFILL_REQ );
    assign o_mem_req.write = ( state == WRITEBACK );
    assign o_mem_req.line  = i_line;
    assign o_mem_req.addr  = ( state == WRITEBACK ) ?
                             { i_lookup.victim_tag, o_index, { `DC_OFFSET_W{ 1'b0 } } } :
                             { o_tag, o_index, { `DC_OFFSET_W{ 1'b0 } } };

    // --------------------
    // State machine.
    // --------------------
    always_comb begin
        state_nxt = state;
        case ( state )
            IDLE:        if ( i_req_valid ) state_nxt = LOOKUP;
            LOOKUP: begin
                if ( i_lookup.hit ) begin
                    state_nxt = RESPOND;
                end
                else if ( i_lookup.victim_dirty ) begin
                    state_nxt = WRITEBACK;
                end
                else begin
                    state_nxt = REFILL_REQ;
                end
            end
            WRITEBACK:   if ( i_mem_ready ) state_nxt = REFILL_REQ;
            REFILL_REQ:  if ( i_mem_ready ) state_nxt = REFILL_WAIT;
            REFILL_WAIT: if ( i_fill_valid ) state_nxt = LOOKUP;
            RESPOND:     if ( i_rsp_ready ) state_nxt = IDLE;
            default:     state_nxt = IDLE;
        endcase
    end

    always_ff @( posedge i_clk, posedge i_arst ) begin
        if ( i_arst ) begin
            state  <= IDLE;
            miss_q <= 1'b0;
        end
        else begin
            state <= state_nxt;
            // Any miss before the final lookup means the first one missed.
            if ( o_req_ready & i_req_valid ) begin
                miss_q <= 1'b0;
            end
            else if ( ( state == LOOKUP ) & ~i_lookup.hit ) begin
                miss_q <= 1'b1;
            end
        end
    end

    // Request and response payload.
    always_ff @( posedge i_clk ) begin
        if ( o_req_ready & i_req_valid ) begin
            req_q <= i_req;
        end
        if ( lookup_hit ) begin
            rsp_data_q <= i_dword;
        end
    end

endmodule

/* verilog/dcache_top.sv */
// Write-back data cache, 4 ways, 2 sets, 64-byte lines.
// Core side is a valid/ready request and response pair.
// Memory side takes one line request at a time; fills come back
// as a one-cycle pulse and cannot be stalled.

module dcache_top (
    input  logic                   i_clk,
    input  logic                   i_arst,
    input  logic                   i_req_valid,
    input  dcache_pkg::cache_req_t i_req,
    output logic                   o_req_ready,
    output logic                   o_rsp_valid,
    output logic                   o_rsp_hit,
    output dcache_pkg::dword_t     o_rsp_data,
    input  logic                   i_rsp_ready,
    output logic                   o_mem_valid,
    output dcache_pkg::mem_req_t   o_mem_req,
    input  logic                   i_mem_ready,
    input  logic                   i_fill_valid,
    input  dcache_pkg::line_t      i_fill_line
);
    import dcache_pkg::*;

    lookup_t lookup;
    line_t   line;
    dword_t  dword;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    size_t   size;
    dword_t  wdata;
    way_t    way;
    way_t    victim;
    logic    store;
    logic    fill;
    logic    touch;

    dcache_ctrl ctrl_inst (
        .i_clk        ( i_clk        ),
        .i_arst       ( i_arst       ),
        .i_req_valid  ( i_req_valid  ),
        .i_req        ( i_req        ),
        .i_rsp_ready  ( i_rsp_ready  ),
        .i_mem_ready  ( i_mem_ready  ),
        .i_fill_valid ( i_fill_valid ),
        .i_lookup     ( lookup       ),
        .i_line       ( line         ),
        .i_dword      ( dword        ),
        .o_req_ready  ( o_req_ready  ),
        .o_rsp_valid  ( o_rsp_valid  ),
        .o_rsp_hit    ( o_rsp_hit    ),
        .o_rsp_data   ( o_rsp_data   ),
        .o_mem_valid  ( o_mem_valid  ),
        .o_mem_req    ( o_mem_req    ),
        .o_index      ( index        ),
        .o_tag        ( tag          ),
        .o_offset     ( offset       ),
        .o_size       ( size         ),
        .o_wdata      ( wdata        ),
        .o_way        ( way          ),
        .o_store      ( store        ),
        .o_fill       ( fill         ),
        .o_touch      ( touch        )
    );

    dcache_tag_array tag_array_inst (
        .i_clk       ( i_clk  ),
        .i_arst      ( i_arst ),
        .i_index     ( index  ),
        .i_tag       ( tag    ),
        .i_victim    ( victim ),
        .i_fill      ( fill   ),
        .i_store_way ( way    ),
        .i_store     ( store  ),
        .o_lookup    ( lookup )
    );

    dcache_plru plru_inst (
        .i_clk       ( i_clk  ),
        .i_arst      ( i_arst ),
        .i_index     ( index  ),
        .i_touch     ( touch  ),
        .i_touch_way ( way    ),
        .o_victim    ( victim )
    );

    dcache_data_array data_array_inst (
        .i_clk       ( i_clk       ),
        .i_index     ( index       ),
        .i_way       ( way         ),
        .i_offset    ( offset      ),
        .i_size      ( size        ),
        .i_wdata     ( wdata       ),
        .i_store     ( store       ),
        .i_fill      ( fill        ),
        .i_fill_line ( i_fill_line ),
        .o_dword     ( dword       ),
        .o_line      ( line        )
    );

endmodule

/* bench/dcache_mem_model.sv */
// Backing memory for the data cache testbench.
// Lines start with an address-derived pattern and keep what is written back.
// Ready stalls and fill delays are random from a fixed seed.
// Holds one outstanding read, as the cache never issues more.

module dcache_mem_model (
    input  logic                 i_clk,
    input  logic                 i_arst,
    input  logic                 i_mem_valid,
    input  dcache_pkg::mem_req_t i_mem_req,
    output logic                 o_mem_ready,
    output logic                 o_fill_valid,
    output dcache_pkg::line_t    o_fill_line
);
    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    line_t         lines [ addr_t ];
    logic          fill_pending;
    addr_t         fill_addr;
    int            fill_wait;
    logic [ 31:0 ] rand_state;

    function automatic logic [ 31:0 ] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return { rand_state[ 15:0 ], rand_state[ 31:16 ] };
    endfunction

    // Every doubleword differs, and every address bit shows up in it.
    function automatic dword_t init_dword( addr_t a );
        return { a ^ 32'hc3a5_5a3c, ~a };
    endfunction

    function automatic line_t read_line( addr_t a );
        line_t l;
        if ( lines.exists( a ) ) begin
            return lines[ a ];
        end
        for ( int d = 0; d < 8; d++ ) begin
            l[ 64*d +: 64 ] = init_dword( a + 8*d );
        end
        return l;
    endfunction

    initial begin
        rand_state   = 32'h9b7a8428;
        fill_pending = 1'b0;
        fill_addr    = '0;
        fill_wait    = 0;
        o_mem_ready  = 1'b0;
        o_fill_valid = 1'b0;
        o_fill_line  = '0;
    end

    // --------------------
    // Responder.
    // --------------------
    always @( negedge i_clk ) begin
        o_fill_valid = 1'b0;
        if ( i_arst ) begin
            fill_pending = 1'b0;
            o_mem_ready  = 1'b0;
        end
        else begin
            // One-cycle fill pulse once the delay runs out.
            if ( fill_pending ) begin
                if ( fill_wait == 0 ) begin
                    o_fill_valid = 1'b1;
                    o_fill_line  = read_line( fill_addr );
                    fill_pending = 1'b0;
                end
                else begin
                    fill_wait--;
                end
            end
            o_mem_ready = ( next_random() % 4 ) != 0;
            // Taken on the coming rising edge.
            if ( i_mem_valid && o_mem_ready ) begin
                if ( i_mem_req.write ) begin
                    lines[ i_mem_req.addr ] = i_mem_req.line;
                    $display( "mem: write-back of line %h", i_mem_req.addr );
                end
                else begin
                    fill_pending = 1'b1;
                    fill_addr    = i_mem_req.addr;
                    fill_wait    = next_random() % 6;
                end
            end
        end
    end

endmodule

/* bench/dcache_tb.sv */
// Testbench for the data cache: random loads and stores over 24 lines,
// checked against a behavioral 4-way cache with the same PLRU rule.
// Inputs change on the falling edge. Memory traffic is checked on the
// rising edge, responses on the falling edge. Stops at the first error.

`include "dcache_macros.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    localparam int NUM_TXNS       = 600;
    localparam int TIMEOUT_CYCLES = NUM_TXNS * 40;
    localparam int NUM_LINES      = 24;

    logic          i_clk;
    logic          i_arst;
    logic          i_req_valid;
    cache_req_t    i_req;
    logic          o_req_ready;
    logic          o_rsp_valid;
    logic          o_rsp_hit;
    dword_t        o_rsp_data;
    logic          i_rsp_ready;
    logic          o_mem_valid;
    mem_req_t      o_mem_req;
    logic          i_mem_ready;
    logic          i_fill_valid;
    line_t         i_fill_line;

    // Reference cache over a flat memory.
    tag_t          ref_tag   [ `DC_SETS ][ `DC_WAYS ];
    logic          ref_valid [ `DC_SETS ][ `DC_WAYS ];
    logic          ref_dirty [ `DC_SETS ][ `DC_WAYS ];
    logic [ 2:0 ]  ref_tree  [ `DC_SETS ];
    dword_t        flat      [ addr_t ];

    addr_t         wb_addr_q [ $ ];
    line_t         wb_line_q [ $ ];
    logic          mem_held = 1'b0;
    mem_req_t      held_req;
    int            cycle_count = 0;
    logic [ 31:0 ] rand_state;

    dcache_top dcache_top_inst (
        .i_clk        ( i_clk        ),
        .i_arst       ( i_arst       ),
        .i_req_valid  ( i_req_valid  ),
        .i_req        ( i_req        ),
        .o_req_ready  ( o_req_ready  ),
        .o_rsp_valid  ( o_rsp_valid  ),
        .o_rsp_hit    ( o_rsp_hit    ),
        .o_rsp_data   ( o_rsp_data   ),
        .i_rsp_ready  ( i_rsp_ready  ),
        .o_mem_valid  ( o_mem_valid  ),
        .o_mem_req    ( o_mem_req    ),
        .i_mem_ready  ( i_mem_ready  ),
        .i_fill_valid ( i_fill_valid ),
        .i_fill_line  ( i_fill_line  )
    );

    dcache_mem_model mem_model_inst (
        .i_clk        ( i_clk        ),
        .i_arst       ( i_arst       ),
        .i_mem_valid  ( o_mem_valid  ),
        .i_mem_req    ( o_mem_req    ),
        .o_mem_ready  ( i_mem_ready  ),
        .o_fill_valid ( i_fill_valid ),
        .o_fill_line  ( i_fill_line  )
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // --------------------
    // Failure reporting.
    // --------------------
    task automatic end_with_failure();
        $display( "TEST FAILED" );
        $fatal( 1 );
    endtask

    task automatic report_mismatch( input string name, input logic [ 511:0 ] got,
                                    input logic [ 511:0 ] exp );
        $display( "ERROR: %s is %0h, expected %0h", name, got, exp );
        end_with_failure();
    endtask

    task automatic report_problem( input string what );
        $display( "ERROR: %s", what );
        end_with_failure();
    endtask

    // --------------------
    // Stimulus and model.
    // --------------------
    function automatic logic [ 31:0 ] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return { rand_state[ 15:0 ], rand_state[ 31:16 ] };
    endfunction

    // Same pattern as the memory model's initial content.
    function automatic dword_t init_dword( addr_t a );
        return { a ^ 32'hc3a5_5a3c, ~a };
    endfunction

    function automatic dword_t read_dword( addr_t a );
        return flat.exists( a ) ? flat[ a ] : init_dword( a );
    endfunction

    function automatic line_t read_line( addr_t a );
        line_t l;
        for ( int d = 0; d < 8; d++ ) begin
            l[ 64*d +: 64 ] = read_dword( a + 8*d );
        end
        return l;
    endfunction

    // Size code n writes 2**n bytes, starting at the aligned offset.
    function automatic dword_t merge_bytes( dword_t old, dword_t wdata, size_t size,
                                            logic [ 2:0 ] off );
        dword_t res;
        res = old;
        for ( int i = 0; i < ( 1 << size ); i++ ) begin
            res[ 8*( off + i ) +: 8 ] = wdata[ 8*i +: 8 ];
        end
        return res;
    endfunction

    function automatic cache_req_t random_request();
        cache_req_t    req;
        logic [ 31:0 ] r;
        int            nb;
        r               = next_random();
        req.addr        = 32'h1000_0000 + ( r % NUM_LINES ) * 32'h0000_1040;
        r               = next_random();
        req.size        = r[ 1:0 ];
        req.write       = r[ 8 ];
        nb              = 1 << r[ 1:0 ];
        req.addr[ 5:3 ] = r[ 4:2 ];
        req.addr[ 2:0 ] = r[ 7:5 ] & ~( nb - 1 );
        req.wdata       = { next_random(), next_random() };
        return req;
    endfunction

    task automatic model_access( input cache_req_t req, output logic hit, output dword_t data );
        index_t idx;
        tag_t   tag;
        way_t   way;
        addr_t  daddr;
        addr_t  vaddr;
        idx   = req.addr[ 6 ];
        tag   = req.addr[ 31:7 ];
        daddr = { req.addr[ 31:3 ], 3'b000 };
        hit   = 1'b0;
        way   = '0;
        for ( int w = 0; w < `DC_WAYS; w++ ) begin
            if ( !hit && ref_valid[ idx ][ w ] && ref_tag[ idx ][ w ] == tag ) begin
                hit = 1'b1;
                way = way_t'( w );
            end
        end
        if ( !hit ) begin
            if ( ref_tree[ idx ][ 0 ] ) begin
                way = ref_tree[ idx ][ 2 ] ? 2'd3 : 2'd2;
            end
            else begin
                way = ref_tree[ idx ][ 1 ] ? 2'd1 : 2'd0;
            end
            // The cache holds the newest copy, so the flat memory has it too.
            if ( ref_valid[ idx ][ way ] && ref_dirty[ idx ][ way ] ) begin
                vaddr = { ref_tag[ idx ][ way ], idx, 6'b000000 };
                wb_addr_q.push_back( vaddr );
                wb_line_q.push_back( read_line( vaddr ) );
            end
            ref_tag[ idx ][ way ]   = tag;
            ref_valid[ idx ][ way ] = 1'b1;
            ref_dirty[ idx ][ way ] = 1'b0;
        end
        ref_tree[ idx ][ 0 ] = ~way[ 1 ];
        if ( way[ 1 ] ) begin
            ref_tree[ idx ][ 2 ] = ~way[ 0 ];
        end
        else begin
            ref_tree[ idx ][ 1 ] = ~way[ 0 ];
        end
        data = read_dword( daddr );
        if ( req.write ) begin
            data                    = merge_bytes( data, req.wdata, req.size, req.addr[ 2:0 ] );
            flat[ daddr ]           = data;
            ref_dirty[ idx ][ way ] = 1'b1;
        end
    endtask

    // --------------------
    // Memory side checks.
    // --------------------
    always @( posedge i_clk ) begin
        cycle_count++;
        if ( cycle_count >= TIMEOUT_CYCLES ) begin
            report_problem( "the run did not finish within the cycle limit" );
        end
        if ( mem_held ) begin
            assert ( o_mem_valid && o_mem_req == held_req )
                else report_problem( "memory request changed while i_mem_ready was low" );
        end
        mem_held = o_mem_valid && !i_mem_ready;
        held_req = o_mem_req;
        if ( o_mem_valid && i_mem_ready && o_mem_req.write ) begin
            assert ( wb_addr_q.size() != 0 )
                else report_problem( "memory write without a dirty victim" );
            assert ( o_mem_req.addr == wb_addr_q[ 0 ] )
                else report_mismatch( "o_mem_req.addr", o_mem_req.addr, wb_addr_q[ 0 ] );
            assert ( o_mem_req.line == wb_line_q[ 0 ] )
                else report_mismatch( "o_mem_req.line", o_mem_req.line, wb_line_q[ 0 ] );
            void'( wb_addr_q.pop_front() );
            void'( wb_line_q.pop_front() );
        end
    end

    // --------------------
    // Core side.
    // --------------------
    initial begin
        cache_req_t req;
        logic       exp_hit;
        dword_t     exp_data;
        int         lat;
        rand_state  = 32'h9b7a8428;
        i_arst      = 1'b1;
        i_req_valid = 1'b0;
        i_req       = '0;
        i_rsp_ready = 1'b0;
        for ( int s = 0; s < `DC_SETS; s++ ) begin
            ref_tree[ s ] = '0;
            for ( int w = 0; w < `DC_WAYS; w++ ) begin
                ref_tag[ s ][ w ]   = '0;
                ref_valid[ s ][ w ] = 1'b0;
                ref_dirty[ s ][ w ] = 1'b0;
            end
        end
        repeat ( 8 ) @( negedge i_clk );
        i_arst = 1'b0;
        @( negedge i_clk );
        assert ( o_req_ready ) else report_mismatch( "o_req_ready", o_req_ready, 1'b1 );
        assert ( !o_rsp_valid ) else report_mismatch( "o_rsp_valid", o_rsp_valid, 1'b0 );
        assert ( !o_mem_valid ) else report_mismatch( "o_mem_valid", o_mem_valid, 1'b0 );

        for ( int n = 0; n < NUM_TXNS; n++ ) begin
            req         = random_request();
            i_req       = req;
            i_req_valid = 1'b1;
            assert ( o_req_ready ) else report_problem( "cache not ready while idle" );
            model_access( req, exp_hit, exp_data );
            // Valid stays high, so a second acceptance would show up here.
            lat = 0;
            do begin
                @( negedge i_clk );
                lat++;
                assert ( !o_req_ready )
                    else report_problem( "cache ready while an access is in flight" );
            end while ( !o_rsp_valid );
            assert ( o_rsp_hit == exp_hit ) else report_mismatch( "o_rsp_hit", o_rsp_hit, exp_hit );
            assert ( o_rsp_data == exp_data )
                else report_mismatch( "o_rsp_data", o_rsp_data, exp_data );
            if ( exp_hit ) begin
                assert ( lat == 2 )
                    else report_problem( $sformatf( "hit answered after %0d cycles, not 2", lat ) );
            end
            assert ( wb_addr_q.size() == 0 )
                else report_problem( "an expected write-back never reached memory" );
            i_rsp_ready = ( next_random() % 3 ) != 0;
            while ( !i_rsp_ready ) begin
                @( negedge i_clk );
                assert ( o_rsp_valid && o_rsp_hit == exp_hit && o_rsp_data == exp_data )
                    else report_problem( "response changed while i_rsp_ready was low" );
                assert ( !o_req_ready )
                    else report_problem( "cache ready before its response was taken" );
                i_rsp_ready = ( next_random() % 3 ) != 0;
            end
            @( negedge i_clk );
        end

        $display( "TEST PASSED" );
        $finish;
    end

endmodule

/* dcache.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_plru.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv
